/* rvSystem.f */
design/rvPkg.sv
design/immDecoder.sv
design/controller.sv
design/alu.sv
design/registerFile.sv
design/cpu.sv
design/dataMemory.sv
design/rvSystem.sv
bench/rvSystemTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module rvSystemTb -f rvSystem.f -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* bench/rvSystemTb.sv */
module rvSystemTb import rvPkg::*; ();

    localparam int clkPeriod = 4;
    localparam int numInstr  = 2000;
    localparam int progWords = 1024;
    // register setup plus one store per data word
    localparam int initWords = 31 + dataWords;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc, retireData, storeAddr, storeData;
    logic        retireWe, storeWe;
    logic [4:0]  retireRd;
    logic [3:0]  storeMask;

    logic [31:0] prog [0:progWords-1];
    logic [31:0] modelRegs [0:31];
    logic [7:0]  modelMem [0:255];
    logic [31:0] modelPc, nextPc, expData, expAddr, expStData;
    logic [31:0] rngState = 32'd2107;
    logic        expWe, expStWe;
    logic [4:0]  expRd;
    logic [3:0]  expMask;
    int          errors = 0;
    int          checks = 0;

    rvSystem i_rvSystem (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .retireWe(retireWe), .retireRd(retireRd), .retireData(retireData),
        .storeWe(storeWe), .storeAddr(storeAddr), .storeData(storeData), .storeMask(storeMask)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] encStore(logic [2:0] f3, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opStore};
    endfunction

    // offset kept aligned to the access size
    function automatic logic [11:0] alignOffset(logic [2:0] f3, logic [7:0] raw);
        return {4'b0, f3[1] ? {raw[7:2], 2'b00} : (f3[0] ? {raw[7:1], 1'b0} : raw)};
    endfunction

    function automatic logic [31:0] arith(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // only the enabled byte lanes carry store data
    function automatic logic lanesMatch(logic [31:0] got, logic [31:0] want, logic [3:0] mask);
        for (int k = 0; k < 4; k++) begin
            if (mask[k] && got[8 * k +: 8] !== want[8 * k +: 8]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic flagError(string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // expected register and memory write of one instruction
    task automatic predict(logic [31:0] ins);
        logic [2:0]  f3;
        logic [31:0] a, b, immI, immS, half;
        logic [7:0]  ad;
        int          nBytes;
        f3 = ins[14:12];
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        expWe = 1'b1;
        expStWe = 1'b0;
        expRd = ins[11:7];
        expData = '0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            opReg:   expData = arith(f3, ins[30], a, b);
            opImm:   expData = arith(f3, ins[30] && f3 == 3'b101, a, immI);
            opLui:   expData = {ins[31:12], 12'b0};
            opAuipc: expData = modelPc + {ins[31:12], 12'b0};
            opJal: begin
                expData = modelPc + 32'd4;
                nextPc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            opJalr: begin
                expData = modelPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            opBranch: begin
                expWe = 1'b0;
                if (branchTaken(f3, a, b)) begin
                    nextPc = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            opLoad: begin
                ad = 8'(a + immI);
                half = {16'b0, modelMem[ad + 8'd1], modelMem[ad]};
                case (f3)
                    3'b000:  expData = {{24{modelMem[ad][7]}}, modelMem[ad]};
                    3'b001:  expData = {{16{half[15]}}, half[15:0]};
                    3'b010:  expData = {modelMem[ad + 8'd3], modelMem[ad + 8'd2], half[15:0]};
                    3'b100:  expData = {24'b0, modelMem[ad]};
                    3'b101:  expData = half;
                    default: expWe = 1'b0;
                endcase
            end
            opStore: begin
                expWe = 1'b0;
                expStWe = (f3 < 3'b011);
                expAddr = a + immS;
                nBytes = (f3 == 3'b000) ? 1 : ((f3 == 3'b001) ? 2 : 4);
                expMask = '0;
                expStData = '0;
                // byte j of rs2 lands in lane addr + j
                for (int j = 0; j < nBytes; j++) begin
                    expMask[expAddr[1:0] + j] = 1'b1;
                    expStData[8 * (expAddr[1:0] + j) +: 8] = b[8 * j +: 8];
                end
            end
            default: expWe = 1'b0;
        endcase
    endtask

    task automatic commit();
        if (expWe && expRd != 5'd0) begin
            modelRegs[expRd] = expData;
        end
        for (int k = 0; k < 4; k++) begin
            if (expStWe && expMask[k]) begin
                modelMem[{expAddr[7:2], 2'(k)}] = expStData[8 * k +: 8];
            end
        end
        modelPc = nextPc;
    endtask

    always @(negedge clk) begin
        if (reset && (retireWe !== 1'b0 || storeWe !== 1'b0)) begin
            flagError("write enable high during reset");
        end
    end

    initial begin
        #((numInstr + 3 + 100) * clkPeriod);
        $display("watchdog timeout, the run did not reach its last instruction");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r, s;
        logic [11:0] imm;
        logic [20:0] off;
        logic [4:0]  kind, rd, rs1, rs2;
        logic [2:0]  f3;
        for (int k = 1; k < 32; k++) begin
            r = nextRand();
            prog[k - 1] = {r[11:0], 5'd0, 3'b000, 5'(k), opImm};
        end
        for (int w = 0; w < dataWords; w++) begin
            prog[31 + w] = encStore(3'b010, 5'(w % 31 + 1), 12'(4 * w));
        end
        for (int i = initWords; i < progWords; i++) begin
            r = nextRand();
            s = nextRand();
            kind = r[4:0];
            rd = r[9:5];
            rs1 = r[14:10];
            rs2 = r[19:15];
            f3 = r[22:20];
            off = 21'((s[3:0] + 1) * 4);
            if (kind < 9) begin
                prog[i] = {1'b0, s[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, opReg};
            end else if (kind < 15 || kind > 29) begin
                // shifts need the shamt form
                imm = (f3[1:0] == 2'b01) ? {1'b0, s[5] && f3[2], 5'b0, s[4:0]} : s[11:0];
                prog[i] = {imm, rs1, f3, rd, opImm};
            end else if (kind < 17) begin
                prog[i] = {s[31:12], rd, s[0] ? opLui : opAuipc};
            end else if (kind < 20) begin
                f3 = (f3 == 3'b011 || f3[2:1] == 2'b11) ? 3'b010 : f3;
                prog[i] = {alignOffset(f3, s[7:0]), 5'd0, f3, rd, opLoad};
            end else if (kind < 23) begin
                f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
                imm = alignOffset(f3, s[7:0]);
                prog[i] = encStore(f3, rs2, imm);
                // read the stored word straight back
                if (i + 1 < progWords) begin
                    i++;
                    prog[i] = {4'b0, imm[7:2], 2'b00, 5'd0, 3'b010, rd, opLoad};
                end
            end else if (kind < 27) begin
                f3 = (f3[2:1] == 2'b01) ? 3'b000 : f3;
                prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
            end else if (kind < 29) begin
                prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
            end else begin
                prog[i] = {12'(384 + 4 * s[4:0]), 5'd0, 3'b000, rd, opJalr};
            end
        end
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = '0;
        end
        for (int k = 0; k < 256; k++) begin
            modelMem[k] = '0;
        end
        modelPc = '0;
        reset = 1'b1;
        instruction = prog[0];
        repeat (2) @(posedge clk);
        #1 instruction = prog[31];
        @(posedge clk);
        #1 reset = 1'b0;
        if (pc !== 32'd0) begin
            flagError($sformatf("pc is %h after reset", pc));
        end
        for (int n = 0; n < numInstr; n++) begin
            instruction = prog[pc[11:2]];
            @(negedge clk);
            checks++;
            if (pc !== modelPc) begin
                flagError($sformatf("pc %h, expected %h", pc, modelPc));
            end
            predict(instruction);
            if (retireWe !== expWe) begin
                flagError($sformatf("retireWe %b for %h at pc %h", retireWe, instruction, pc));
            end else if (expWe && (retireRd !== expRd || retireData !== expData)) begin
                flagError($sformatf("x%0d = %h, expected x%0d = %h", retireRd, retireData,
                                    expRd, expData));
            end
            if (storeWe !== expStWe) begin
                flagError($sformatf("storeWe %b for %h at pc %h", storeWe, instruction, pc));
            end else if (expStWe && (storeAddr !== expAddr || storeMask !== expMask
                                     || !lanesMatch(storeData, expStData, expMask))) begin
                flagError($sformatf("store %h %h %b, expected %h %h %b", storeAddr, storeData,
                                    storeMask, expAddr, expStData, expMask));
            end
            commit();
            @(posedge clk);
            #1;
        end
        $display("%0d errors in %0d checked instructions", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* design/rvSystem.sv */
module rvSystem import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     instruction,
    output logic [xLen-1:0] pc,
    output logic            retireWe,
    output logic [4:0]      retireRd,
    output logic [xLen-1:0] retireData,
    output logic            storeWe,
    output logic [xLen-1:0] storeAddr,
    output logic [xLen-1:0] storeData,
    output logic [3:0]      storeMask
);

    logic [xLen-1:0] memReadData;

    // trace ports share the nets of the memory link and register write
    cpu iCpu (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .memReadData(memReadData),
        .pc(pc),
        .memAddr(storeAddr),
        .memWriteData(storeData),
        .wrMask(storeMask),
        .memWr(storeWe),
        .regWe(retireWe),
        .regDest(retireRd),
        .regResult(retireData)
    );

    dataMemory iDataMemory (
        .clk(clk),
        .addr(storeAddr),
        .writeData(storeData),
        .wrMask(storeMask),
        .we(storeWe),
        .readData(memReadData)
    );

endmodule

/* design/dataMemory.sv */
module dataMemory import rvPkg::*; (
    input  logic            clk,
    input  logic [xLen-1:0] addr,
    input  logic [xLen-1:0] writeData,
    input  logic [3:0]      wrMask,
    input  logic            we,
    output logic [xLen-1:0] readData
);

    logic [xLen-1:0] mem [0:dataWords-1];
    logic [5:0]      wordIdx;

    // address wraps at 256 bytes
    assign wordIdx = addr[7:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we && wrMask[i]) begin
                mem[wordIdx][8 * i +: 8] <= writeData[8 * i +: 8];
            end
        end
    end

    assign readData = mem[wordIdx];

endmodule

/* design/cpu.sv */
module cpu import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     instruction,
    input  logic [xLen-1:0] memReadData,
    output logic [xLen-1:0] pc,
    output logic [xLen-1:0] memAddr,
    output logic [xLen-1:0] memWriteData,
    output logic [3:0]      wrMask,
    output logic            memWr,
    output logic            regWe,
    output logic [4:0]      regDest,
    output logic [xLen-1:0] regResult
);

    instrWord        instr;
    logic            aluZero, aluImm, aluToPc, branch, loadUnsigned;
    logic            memToReg, ctrlMemWr, ctrlRegWr;
    logic [1:0]      loadSize, storeSize, regDataSel;
    logic [3:0]      aluCtrl;
    logic [3:0]      sizeMask;
    logic [7:0]      loadByte;
    logic [15:0]     loadHalf;
    logic [xLen-1:0] rs1, rs2, aluOp2, aluRes, imm, pc4, immPc, target, regData, loadData;

    assign instr = instruction;

    controller iController (
        .instruction(instr), .aluZero(aluZero), .aluCtrl(aluCtrl), .aluImm(aluImm),
        .aluToPc(aluToPc), .branch(branch), .loadSize(loadSize),
        .loadUnsigned(loadUnsigned), .storeSize(storeSize), .memToReg(memToReg),
        .memWr(ctrlMemWr), .regDataSel(regDataSel), .regWr(ctrlRegWr)
    );

    alu iAlu (.op1(rs1), .op2(aluOp2), .ctrl(aluCtrl), .zero(aluZero), .res(aluRes));

    immDecoder iImmDecoder (.instruction(instr), .imm(imm));

    registerFile iRegisterFile (
        .clk(clk), .a1(instr.rType.rs1), .a2(instr.rType.rs2), .a3(instr.rType.rd),
        .di3(regResult), .we3(regWe), .rd1(rs1), .rd2(rs2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= branch ? target : pc4;
        end
    end

    assign pc4    = pc + 32'd4;
    assign immPc  = pc + imm;
    // jalr target has bit 0 cleared
    assign target = aluToPc ? {aluRes[xLen-1:1], 1'b0} : immPc;
    assign aluOp2 = aluImm ? imm : rs2;

    always_comb begin
        case (regDataSel)
            selAlu:   regData = aluRes;
            selImmPc: regData = immPc;
            selImm:   regData = imm;
            default:  regData = pc4;
        endcase
    end

    // byte lane picked by the low address bits
    assign loadByte = memReadData[8 * aluRes[1:0] +: 8];
    assign loadHalf = aluRes[1] ? memReadData[31:16] : memReadData[15:0];

    always_comb begin
        case (loadSize)
            sizeByte: loadData = {{24{loadByte[7] & ~loadUnsigned}}, loadByte};
            sizeHalf: loadData = {{16{loadHalf[15] & ~loadUnsigned}}, loadHalf};
            default:  loadData = memReadData;
        endcase
    end

    always_comb begin
        case (storeSize)
            sizeByte: sizeMask = 4'b0001;
            sizeHalf: sizeMask = 4'b0011;
            default:  sizeMask = 4'b1111;
        endcase
    end

    assign memAddr      = aluRes;
    assign memWriteData = rs2 << {aluRes[1:0], 3'b000};
    assign wrMask       = sizeMask << aluRes[1:0];
    assign memWr        = ctrlMemWr & ~reset;
    assign regWe        = ctrlRegWr & ~reset;
    assign regDest      = instr.rType.rd;
    assign regResult    = memToReg ? loadData : regData;

endmodule

/* design/registerFile.sv */
module registerFile import rvPkg::*; (
    input  logic            clk,
    input  logic [4:0]      a1,
    input  logic [4:0]      a2,
    input  logic [4:0]      a3,
    input  logic [xLen-1:0] di3,
    input  logic            we3,
    output logic [xLen-1:0] rd1,
    output logic [xLen-1:0] rd2
);

    // x0 has no storage
    logic [xLen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we3 && a3 != 5'd0) begin
            regs[a3] <= di3;
        end
    end

    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];

endmodule

/* design/alu.sv */
module alu import rvPkg::*; (
    input  logic [xLen-1:0] op1,
    input  logic [xLen-1:0] op2,
    input  logic [3:0]      ctrl,
    output logic            zero,
    output logic [xLen-1:0] res
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (ctrl)
            aluAdd:  res = op1 + op2;
            aluSub:  res = op1 - op2;
            aluSll:  res = op1 << shamt;
            aluSlt:  res = {{(xLen - 1){1'b0}}, $signed(op1) < $signed(op2)};
            aluSltu: res = {{(xLen - 1){1'b0}}, op1 < op2};
            aluXor:  res = op1 ^ op2;
            aluSrl:  res = op1 >> shamt;
            aluSra:  res = $unsigned($signed(op1) >>> shamt);
            aluOr:   res = op1 | op2;
            aluAnd:  res = op1 & op2;
            default: res = '0;
        endcase
    end

    // branches test this flag
    assign zero = (res == '0);

endmodule

/* design/controller.sv */
module controller import rvPkg::*; (
    input  instrWord   instruction,
    input  logic       aluZero,
    output logic [3:0] aluCtrl,
    output logic       aluImm,
    output logic       aluToPc,
    output logic       branch,
    output logic [1:0] loadSize,
    output logic       loadUnsigned,
    output logic [1:0] storeSize,
    output logic       memToReg,
    output logic       memWr,
    output logic [1:0] regDataSel,
    output logic       regWr
);

    logic [2:0] funct3;
    logic       funct7b5;
    logic [3:0] opAluCtrl;

    assign funct3   = instruction.iType.funct3;
    assign funct7b5 = instruction.rType.funct7[5];

    // funct3 to alu op; sub only exists for register operands
    always_comb begin
        case (funct3)
            3'b000:  opAluCtrl = (instruction.rType.opcode == opReg && funct7b5) ? aluSub : aluAdd;
            3'b001:  opAluCtrl = aluSll;
            3'b010:  opAluCtrl = aluSlt;
            3'b011:  opAluCtrl = aluSltu;
            3'b100:  opAluCtrl = aluXor;
            3'b101:  opAluCtrl = funct7b5 ? aluSra : aluSrl;
            3'b110:  opAluCtrl = aluOr;
            default: opAluCtrl = aluAnd;
        endcase
    end

    always_comb begin
        aluCtrl      = aluAdd;
        aluImm       = 1'b0;
        aluToPc      = 1'b0;
        branch       = 1'b0;
        loadSize     = funct3[1:0];
        loadUnsigned = funct3[2];
        storeSize    = funct3[1:0];
        memToReg     = 1'b0;
        memWr        = 1'b0;
        regDataSel   = selAlu;
        regWr        = 1'b0;
        case (instruction.rType.opcode)
            opReg: begin
                aluCtrl = opAluCtrl;
                regWr   = 1'b1;
            end
            opImm: begin
                aluCtrl = opAluCtrl;
                aluImm  = 1'b1;
                regWr   = 1'b1;
            end
            opLui: begin
                regDataSel = selImm;
                regWr      = 1'b1;
            end
            opAuipc: begin
                regDataSel = selImmPc;
                regWr      = 1'b1;
            end
            opJal: begin
                branch     = 1'b1;
                regDataSel = selPc4;
                regWr      = 1'b1;
            end
            opJalr: begin
                aluImm     = 1'b1;
                aluToPc    = 1'b1;
                branch     = 1'b1;
                regDataSel = selPc4;
                regWr      = 1'b1;
            end
            opBranch: begin
                // beq/bne compare by subtract, the rest by set-less-than
                aluCtrl = funct3[2] ? (funct3[1] ? aluSltu : aluSlt) : aluSub;
                branch  = (funct3[2:1] != 2'b01) & (aluZero ^ funct3[0] ^ funct3[2]);
            end
            opLoad: begin
                aluImm   = 1'b1;
                memToReg = 1'b1;
                regWr    = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            end
            opStore: begin
                aluImm = 1'b1;
                memWr  = !funct3[2] && (funct3[1:0] != 2'b11);
            end
            default: begin
                // fence, system and unknown words retire as nops
            end
        endcase
    end

endmodule

/* design/immDecoder.sv */
module immDecoder import rvPkg::*; (
    input  instrWord    instruction,
    output logic [31:0] imm
);

    always_comb begin
        case (instruction.rType.opcode)
            opImm, opLoad, opJalr:
                imm = {{20{instruction.iType.imm11to0[11]}}, instruction.iType.imm11to0};
            opStore:
                imm = {{20{instruction.sType.imm11to5[6]}}, instruction.sType.imm11to5,
                       instruction.sType.imm4to0};
            opBranch:
                imm = {{20{instruction.bType.imm12}}, instruction.bType.imm11,
                       instruction.bType.imm10to5, instruction.bType.imm4to1, 1'b0};
            opLui, opAuipc:
                imm = {instruction.uType.imm31to12, 12'b0};
            opJal:
                imm = {{12{instruction.jType.imm20}}, instruction.jType.imm19to12,
                       instruction.jType.imm11, instruction.jType.imm10to1, 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

/* design/rvPkg.sv */
package rvPkg;

    localparam int xLen = 32;
    localparam int dataWords = 64;

    // major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    localparam logic [3:0] aluAdd  = 4'b0000;
    localparam logic [3:0] aluSll  = 4'b0001;
    localparam logic [3:0] aluSlt  = 4'b0010;
    localparam logic [3:0] aluSltu = 4'b0011;
    localparam logic [3:0] aluXor  = 4'b0100;
    localparam logic [3:0] aluSrl  = 4'b0101;
    localparam logic [3:0] aluOr   = 4'b0110;
    localparam logic [3:0] aluAnd  = 4'b0111;
    localparam logic [3:0] aluSub  = 4'b1000;
    localparam logic [3:0] aluSra  = 4'b1101;

    // register result source
    localparam logic [1:0] selAlu   = 2'b00;
    localparam logic [1:0] selImmPc = 2'b01;
    localparam logic [1:0] selImm   = 2'b10;
    localparam logic [1:0] selPc4   = 2'b11;

    // same encoding as funct3[1:0] of loads and stores
    localparam logic [1:0] sizeByte = 2'b00;
    localparam logic [1:0] sizeHalf = 2'b01;
    localparam logic [1:0] sizeWord = 2'b10;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrWord;

endpackage
